// ==== verilog/lsu_bus_pkg.sv ====
`default_nettype none

package lsu_bus_pkg;

    // One host memory or channel stream word
    typedef logic [31:0] word_t;

    // Host memory word address
    typedef logic [15:0] addr_t;

    // DMA transfer length in words
    typedef logic [9:0] count_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_isa_pkg.sv ====
`default_nettype none

package lsu_isa_pkg;

    typedef enum logic [3:0] {
        OP_FINISH  = 4'b0000,
        OP_MUL     = 4'b0010,
        OP_ROUTE   = 4'b0100,
        OP_LOAD    = 4'b0101,
        OP_RREWIND = 4'b1000,
        OP_RSIZE   = 4'b1001,
        OP_WREWIND = 4'b1100,
        OP_WSIZE   = 4'b1101
    } opcode_t;

    typedef logic [3:0] operand_t;
    typedef logic [3:0] route_t;
    typedef logic [5:0] pc_t;

    typedef struct packed {
        opcode_t  op;
        operand_t arg;
    } instr_t;

    // Operands of ROUTE and LOAD
    localparam operand_t ROUTE_A   = 4'h0;
    localparam operand_t ROUTE_B   = 4'h1;
    localparam operand_t ROUTE_CNT = 4'h8;

    // Operands of WSIZE and RSIZE
    localparam operand_t SIZE_1   = 4'h0;
    localparam operand_t SIZE_CNT = 4'h1;

    localparam pc_t SAVE_ENTRY = 6'h00;
    localparam pc_t LOAD_ENTRY = 6'h0e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_WREWIND,
        ST_WSIZE,
        ST_WWAIT,
        ST_RREWIND,
        ST_RSIZE,
        ST_RWAIT
    } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_microcode_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_microcode_rom import lsu_isa_pkg::*; #(
    parameter int A_ITEM_WORDS = 2,
    parameter int B_ITEM_WORDS = 1
) (
    input  pc_t    addr,
    output instr_t instr
);

    localparam operand_t A_MUL = operand_t'(A_ITEM_WORDS);
    localparam operand_t B_MUL = operand_t'(B_ITEM_WORDS);

    always_comb begin
        case (addr)
            // Save procedure writes each count word ahead of the channel's items
            SAVE_ENTRY:          instr = {OP_WREWIND, 4'h0};
            SAVE_ENTRY + 6'd1:   instr = {OP_LOAD,    ROUTE_A};
            SAVE_ENTRY + 6'd2:   instr = {OP_ROUTE,   ROUTE_CNT};
            SAVE_ENTRY + 6'd3:   instr = {OP_WSIZE,   SIZE_1};
            SAVE_ENTRY + 6'd4:   instr = {OP_MUL,     A_MUL};
            SAVE_ENTRY + 6'd5:   instr = {OP_ROUTE,   ROUTE_A};
            SAVE_ENTRY + 6'd6:   instr = {OP_WSIZE,   SIZE_CNT};
            SAVE_ENTRY + 6'd7:   instr = {OP_LOAD,    ROUTE_B};
            SAVE_ENTRY + 6'd8:   instr = {OP_ROUTE,   ROUTE_CNT};
            SAVE_ENTRY + 6'd9:   instr = {OP_WSIZE,   SIZE_1};
            SAVE_ENTRY + 6'd10:  instr = {OP_MUL,     B_MUL};
            SAVE_ENTRY + 6'd11:  instr = {OP_ROUTE,   ROUTE_B};
            SAVE_ENTRY + 6'd12:  instr = {OP_WSIZE,   SIZE_CNT};
            SAVE_ENTRY + 6'd13:  instr = {OP_FINISH,  4'h0};
            // Load procedure puts each count word into cnt before the items
            LOAD_ENTRY:          instr = {OP_RREWIND, 4'h0};
            LOAD_ENTRY + 6'd1:   instr = {OP_ROUTE,   ROUTE_CNT};
            LOAD_ENTRY + 6'd2:   instr = {OP_RSIZE,   SIZE_1};
            LOAD_ENTRY + 6'd3:   instr = {OP_MUL,     A_MUL};
            LOAD_ENTRY + 6'd4:   instr = {OP_ROUTE,   ROUTE_A};
            LOAD_ENTRY + 6'd5:   instr = {OP_RSIZE,   SIZE_CNT};
            LOAD_ENTRY + 6'd6:   instr = {OP_ROUTE,   ROUTE_CNT};
            LOAD_ENTRY + 6'd7:   instr = {OP_RSIZE,   SIZE_1};
            LOAD_ENTRY + 6'd8:   instr = {OP_MUL,     B_MUL};
            LOAD_ENTRY + 6'd9:   instr = {OP_ROUTE,   ROUTE_B};
            LOAD_ENTRY + 6'd10:  instr = {OP_RSIZE,   SIZE_CNT};
            LOAD_ENTRY + 6'd11:  instr = {OP_FINISH,  4'h0};
            default:             instr = {OP_FINISH,  4'h0};
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer import lsu_bus_pkg::*, lsu_isa_pkg::*; #(
    parameter int A_ITEM_WORDS = 2,
    parameter int B_ITEM_WORDS = 1
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   save,
    input  logic   load,
    output logic   complete,

    input  count_t a_count,
    input  count_t b_count,

    output logic   wrewind,
    output logic   wcount_valid,
    input  logic   wcount_ready,
    output count_t wcount,
    input  logic   w_idle,

    output logic   rrewind,
    output logic   rcount_valid,
    input  logic   rcount_ready,
    output count_t rcount,
    input  logic   r_idle,

    output route_t route,
    output logic   save_en,
    output logic   load_en,
    output word_t  cnt,

    input  logic   loaded_count_valid,
    input  word_t  loaded_count
);

    seq_state_t state;
    seq_state_t state_next;
    pc_t        pc;
    instr_t     instr;
    instr_t     rom_instr;
    count_t     size_count;

    lsu_microcode_rom #(
        .A_ITEM_WORDS (A_ITEM_WORDS),
        .B_ITEM_WORDS (B_ITEM_WORDS)
    ) i_rom (
        .addr  (pc),
        .instr (rom_instr)
    );

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (save || load) begin
                    state_next = ST_FETCH;
                end
            ST_FETCH:
                state_next = ST_DECODE;
            ST_DECODE:
                case (instr.op)
                    OP_MUL, OP_ROUTE, OP_LOAD: state_next = ST_FETCH;
                    OP_WREWIND:                state_next = ST_WREWIND;
                    OP_WSIZE:                  state_next = ST_WSIZE;
                    OP_RREWIND:                state_next = ST_RREWIND;
                    OP_RSIZE:                  state_next = ST_RSIZE;
                    default:                   state_next = ST_IDLE;
                endcase
            ST_WREWIND, ST_RREWIND:
                state_next = ST_FETCH;
            ST_WSIZE:
                if (wcount_ready) begin
                    state_next = ST_WWAIT;
                end
            ST_WWAIT:
                if (w_idle) begin
                    state_next = ST_FETCH;
                end
            ST_RSIZE:
                if (rcount_ready) begin
                    state_next = ST_RWAIT;
                end
            ST_RWAIT:
                if (r_idle) begin
                    state_next = ST_FETCH;
                end
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            pc    <= SAVE_ENTRY;
            instr <= {OP_FINISH, 4'h0};
            route <= ROUTE_CNT;
        end else begin
            state <= state_next;
            if (state == ST_IDLE) begin
                // Save wins over a simultaneous load
                pc <= save ? SAVE_ENTRY : LOAD_ENTRY;
            end else if (state == ST_FETCH) begin
                pc    <= pc + 6'd1;
                instr <= rom_instr;
            end
            if (state == ST_DECODE && instr.op == OP_ROUTE) begin
                route <= instr.arg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DECODE && instr.op == OP_MUL) begin
            cnt <= cnt * word_t'(instr.arg);
        end else if (state == ST_DECODE && instr.op == OP_LOAD) begin
            cnt <= (instr.arg == ROUTE_B) ? word_t'(b_count) : word_t'(a_count);
        end else if (loaded_count_valid) begin
            cnt <= loaded_count;
        end
    end

    assign size_count   = (instr.arg == SIZE_CNT) ? count_t'(cnt) : count_t'(1);

    assign wrewind      = state == ST_WREWIND;
    assign wcount_valid = state == ST_WSIZE;
    assign wcount       = size_count;
    assign rrewind      = state == ST_RREWIND;
    assign rcount_valid = state == ST_RSIZE;
    assign rcount       = size_count;

    assign save_en      = state == ST_WWAIT;
    assign load_en      = state == ST_RWAIT;
    assign complete     = state == ST_DECODE && instr.op == OP_FINISH;

endmodule

`default_nettype wire

// ==== verilog/lsu_save_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_save_mux import lsu_bus_pkg::*, lsu_isa_pkg::*; (
    input  logic   save_en,
    input  route_t route,
    input  word_t  cnt,

    input  logic   save_a_valid,
    output logic   save_a_ready,
    input  word_t  save_a_data,
    input  logic   save_b_valid,
    output logic   save_b_ready,
    input  word_t  save_b_data,

    output logic   wdata_valid,
    input  logic   wdata_ready,
    output word_t  wdata
);

    always_comb begin
        wdata_valid  = 1'b0;
        wdata        = cnt;
        save_a_ready = 1'b0;
        save_b_ready = 1'b0;
        if (save_en) begin
            case (route)
                ROUTE_CNT: wdata_valid = 1'b1;
                ROUTE_A: begin
                    wdata_valid  = save_a_valid;
                    wdata        = save_a_data;
                    save_a_ready = wdata_ready;
                end
                ROUTE_B: begin
                    wdata_valid  = save_b_valid;
                    wdata        = save_b_data;
                    save_b_ready = wdata_ready;
                end
                default: wdata_valid = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_load_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_demux import lsu_bus_pkg::*, lsu_isa_pkg::*; (
    input  logic   load_en,
    input  route_t route,

    input  logic   rdata_valid,
    output logic   rdata_ready,
    input  word_t  rdata,

    output logic   load_a_valid,
    input  logic   load_a_ready,
    output word_t  load_a_data,
    output logic   load_b_valid,
    input  logic   load_b_ready,
    output word_t  load_b_data,

    output logic   loaded_count_valid,
    output word_t  loaded_count
);

    always_comb begin
        rdata_ready        = 1'b0;
        load_a_valid       = 1'b0;
        load_b_valid       = 1'b0;
        loaded_count_valid = 1'b0;
        if (load_en) begin
            case (route)
                ROUTE_CNT: begin
                    // Sequencer takes count words without back-pressure
                    rdata_ready        = 1'b1;
                    loaded_count_valid = rdata_valid;
                end
                ROUTE_A: begin
                    load_a_valid = rdata_valid;
                    rdata_ready  = load_a_ready;
                end
                ROUTE_B: begin
                    load_b_valid = rdata_valid;
                    rdata_ready  = load_b_ready;
                end
                default: rdata_ready = 1'b0;
            endcase
        end
    end

    assign load_a_data  = rdata;
    assign load_b_data  = rdata;
    assign loaded_count = rdata;

endmodule

`default_nettype wire

// ==== verilog/lsu_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_dma import lsu_bus_pkg::*; #(
    parameter addr_t BASE_ADDR = '0
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   wrewind,
    input  logic   wcount_valid,
    output logic   wcount_ready,
    input  count_t wcount,
    input  logic   wdata_valid,
    output logic   wdata_ready,
    input  word_t  wdata,
    output logic   w_idle,

    input  logic   rrewind,
    input  logic   rcount_valid,
    output logic   rcount_ready,
    input  count_t rcount,
    output logic   rdata_valid,
    input  logic   rdata_ready,
    output word_t  rdata,
    output logic   r_idle,

    output logic   mem_valid,
    input  logic   mem_ready,
    output logic   mem_write,
    output addr_t  mem_addr,
    output word_t  mem_wdata,
    input  logic   mem_rvalid,
    input  word_t  mem_rdata
);

    addr_t  waddr;
    count_t wcnt;
    logic   w_busy;
    logic   w_fire;

    addr_t  raddr;
    count_t rcnt;
    logic   r_pend;
    logic   r_req;
    logic   r_take;

    assign w_busy       = wcnt != '0;
    assign w_idle       = !w_busy;
    assign wcount_ready = w_idle;
    assign wdata_ready  = w_busy && mem_ready;
    assign w_fire       = wdata_valid && wdata_ready;

    // At most one read in flight and only into an empty output register
    assign r_req        = rcnt != '0 && !r_pend && !rdata_valid;
    assign r_take       = r_req && !w_busy && mem_ready;
    assign r_idle       = rcnt == '0 && !r_pend && !rdata_valid;
    assign rcount_ready = r_idle;

    assign mem_valid    = w_busy ? wdata_valid : r_req;
    assign mem_write    = w_busy;
    assign mem_addr     = w_busy ? waddr : raddr;
    assign mem_wdata    = wdata;

    always_ff @(posedge clk) begin
        if (wrewind) begin
            waddr <= BASE_ADDR;
        end else if (w_fire) begin
            waddr <= waddr + addr_t'(1);
        end
        if (rrewind) begin
            raddr <= BASE_ADDR;
        end else if (r_take) begin
            raddr <= raddr + addr_t'(1);
        end
        if (mem_rvalid) begin
            rdata <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wcnt        <= '0;
            rcnt        <= '0;
            r_pend      <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            if (wcount_valid && wcount_ready) begin
                wcnt <= wcount;
            end else if (w_fire) begin
                wcnt <= wcnt - count_t'(1);
            end
            if (rcount_valid && rcount_ready) begin
                rcnt <= rcount;
            end else if (r_take) begin
                rcnt <= rcnt - count_t'(1);
            end
            if (r_take) begin
                r_pend <= 1'b1;
            end else if (mem_rvalid) begin
                r_pend <= 1'b0;
            end
            if (mem_rvalid) begin
                rdata_valid <= 1'b1;
            end else if (rdata_ready) begin
                rdata_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_bus_pkg::*, lsu_isa_pkg::*; #(
    parameter int    A_ITEM_WORDS = 2,
    parameter int    B_ITEM_WORDS = 1,
    parameter addr_t BASE_ADDR    = '0
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   save,
    input  logic   load,
    output logic   complete,

    input  logic   save_a_valid,
    output logic   save_a_ready,
    input  word_t  save_a_data,
    input  logic   save_b_valid,
    output logic   save_b_ready,
    input  word_t  save_b_data,

    output logic   load_a_valid,
    input  logic   load_a_ready,
    output word_t  load_a_data,
    output logic   load_b_valid,
    input  logic   load_b_ready,
    output word_t  load_b_data,

    input  count_t a_count,
    input  count_t b_count,

    output logic   mem_valid,
    input  logic   mem_ready,
    output logic   mem_write,
    output addr_t  mem_addr,
    output word_t  mem_wdata,
    input  logic   mem_rvalid,
    input  word_t  mem_rdata
);

    logic   wrewind;
    logic   wcount_valid;
    logic   wcount_ready;
    count_t wcount;
    logic   w_idle;
    logic   rrewind;
    logic   rcount_valid;
    logic   rcount_ready;
    count_t rcount;
    logic   r_idle;

    route_t route;
    logic   save_en;
    logic   load_en;
    word_t  cnt;

    logic   wdata_valid;
    logic   wdata_ready;
    word_t  wdata;
    logic   rdata_valid;
    logic   rdata_ready;
    word_t  rdata;
    logic   loaded_count_valid;
    word_t  loaded_count;

    lsu_sequencer #(
        .A_ITEM_WORDS (A_ITEM_WORDS),
        .B_ITEM_WORDS (B_ITEM_WORDS)
    ) i_sequencer (
        .clk                (clk),
        .rst                (rst),
        .save               (save),
        .load               (load),
        .complete           (complete),
        .a_count            (a_count),
        .b_count            (b_count),
        .wrewind            (wrewind),
        .wcount_valid       (wcount_valid),
        .wcount_ready       (wcount_ready),
        .wcount             (wcount),
        .w_idle             (w_idle),
        .rrewind            (rrewind),
        .rcount_valid       (rcount_valid),
        .rcount_ready       (rcount_ready),
        .rcount             (rcount),
        .r_idle             (r_idle),
        .route              (route),
        .save_en            (save_en),
        .load_en            (load_en),
        .cnt                (cnt),
        .loaded_count_valid (loaded_count_valid),
        .loaded_count       (loaded_count)
    );

    lsu_save_mux i_save_mux (
        .save_en      (save_en),
        .route        (route),
        .cnt          (cnt),
        .save_a_valid (save_a_valid),
        .save_a_ready (save_a_ready),
        .save_a_data  (save_a_data),
        .save_b_valid (save_b_valid),
        .save_b_ready (save_b_ready),
        .save_b_data  (save_b_data),
        .wdata_valid  (wdata_valid),
        .wdata_ready  (wdata_ready),
        .wdata        (wdata)
    );

    lsu_load_demux i_load_demux (
        .load_en            (load_en),
        .route              (route),
        .rdata_valid        (rdata_valid),
        .rdata_ready        (rdata_ready),
        .rdata              (rdata),
        .load_a_valid       (load_a_valid),
        .load_a_ready       (load_a_ready),
        .load_a_data        (load_a_data),
        .load_b_valid       (load_b_valid),
        .load_b_ready       (load_b_ready),
        .load_b_data        (load_b_data),
        .loaded_count_valid (loaded_count_valid),
        .loaded_count       (loaded_count)
    );

    lsu_dma #(
        .BASE_ADDR (BASE_ADDR)
    ) i_dma (
        .clk          (clk),
        .rst          (rst),
        .wrewind      (wrewind),
        .wcount_valid (wcount_valid),
        .wcount_ready (wcount_ready),
        .wcount       (wcount),
        .wdata_valid  (wdata_valid),
        .wdata_ready  (wdata_ready),
        .wdata        (wdata),
        .w_idle       (w_idle),
        .rrewind      (rrewind),
        .rcount_valid (rcount_valid),
        .rcount_ready (rcount_ready),
        .rcount       (rcount),
        .rdata_valid  (rdata_valid),
        .rdata_ready  (rdata_ready),
        .rdata        (rdata),
        .r_idle       (r_idle),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_bus_pkg::*;
();

    localparam int    A_ITEM_WORDS  = 2;
    localparam int    B_ITEM_WORDS  = 3;
    localparam addr_t BASE_ADDR     = 16'h0240;
    localparam int    MEM_WORDS     = 65536;
    localparam int    SETTLE_CYCLES = 10;
    localparam word_t A_TAG         = 32'ha000_0000;
    localparam word_t B_TAG         = 32'hb000_0000;

    // Test table rows of a_count, b_count, memory stall and sink stall
    localparam int NUM_ROWS = 4;
    localparam int ROW_A [NUM_ROWS]          = '{0, 1, 4, 5};
    localparam int ROW_B [NUM_ROWS]          = '{0, 3, 0, 7};
    localparam bit ROW_MEM_STALL [NUM_ROWS]  = '{1'b0, 1'b1, 1'b0, 1'b1};
    localparam bit ROW_SINK_STALL [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};

    function automatic int image_words(input int r);
        return 2 + ROW_A[r] * A_ITEM_WORDS + ROW_B[r] * B_ITEM_WORDS;
    endfunction

    function automatic int total_image_words();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += image_words(r);
        end
        return total;
    endfunction

    localparam int CYCLE_LIMIT = total_image_words() * 40 + 1000;

    logic   clk;
    logic   rst;
    logic   save;
    logic   load;
    logic   complete;
    logic   save_a_valid = 1'b0;
    logic   save_a_ready;
    word_t  save_a_data  = A_TAG;
    logic   save_b_valid = 1'b0;
    logic   save_b_ready;
    word_t  save_b_data  = B_TAG;
    logic   load_a_valid;
    logic   load_a_ready = 1'b0;
    word_t  load_a_data;
    logic   load_b_valid;
    logic   load_b_ready = 1'b0;
    word_t  load_b_data;
    count_t a_count;
    count_t b_count;
    logic   mem_valid;
    logic   mem_ready    = 1'b0;
    logic   mem_write;
    addr_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_rvalid   = 1'b0;
    word_t  mem_rdata    = '0;

    logic [31:0] rnd           = '0;
    int          seed          = 32'hb5e9_b1e4;
    logic        mem_stall_en  = 1'b0;
    logic        sink_stall_en = 1'b0;
    logic        fill_req      = 1'b0;
    word_t       mem [MEM_WORDS];
    logic        rd_busy       = 1'b0;
    logic [1:0]  rd_wait       = '0;
    addr_t       rd_addr       = '0;
    int          write_count   = 0;
    int          read_count    = 0;
    int          proto_errors  = 0;
    int          a_sent        = 0;
    int          b_sent        = 0;
    word_t       got_a [$];
    word_t       got_b [$];
    int          cycles        = 0;
    int          errors        = 0;
    int          a_start;
    int          b_start;
    int          ga_start;
    int          gb_start;
    word_t       exp_img [$];
    word_t       exp_a [$];
    word_t       exp_b [$];

    lsu_top #(
        .A_ITEM_WORDS (A_ITEM_WORDS),
        .B_ITEM_WORDS (B_ITEM_WORDS),
        .BASE_ADDR    (BASE_ADDR)
    ) i_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .save         (save),
        .load         (load),
        .complete     (complete),
        .save_a_valid (save_a_valid),
        .save_a_ready (save_a_ready),
        .save_a_data  (save_a_data),
        .save_b_valid (save_b_valid),
        .save_b_ready (save_b_ready),
        .save_b_data  (save_b_data),
        .load_a_valid (load_a_valid),
        .load_a_ready (load_a_ready),
        .load_a_data  (load_a_data),
        .load_b_valid (load_b_valid),
        .load_b_ready (load_b_ready),
        .load_b_data  (load_b_data),
        .a_count      (a_count),
        .b_count      (b_count),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

    function automatic word_t fill_word(input addr_t addr);
        return {~addr, addr};
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        rnd <= $random(seed);
    end

    // Host memory with random ready and read latency
    always @(posedge clk) begin
        mem_rvalid <= 1'b0;
        mem_ready  <= !rst && (!mem_stall_en || rnd[1:0] != 2'b00);
        if (fill_req) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[addr_t'(i)] <= fill_word(addr_t'(i));
            end
        end
        if (!rst && mem_valid && mem_ready) begin
            if (mem_write) begin
                mem[mem_addr] <= mem_wdata;
                write_count   <= write_count + 1;
            end else begin
                if (rd_busy) begin
                    proto_errors <= proto_errors + 1;
                    $display("Error at %0t: read issued while another read is outstanding",
                             $time);
                end
                rd_busy    <= 1'b1;
                rd_wait    <= mem_stall_en ? rnd[3:2] : 2'b00;
                rd_addr    <= mem_addr;
                read_count <= read_count + 1;
            end
        end else if (rd_busy) begin
            if (rd_wait == 2'b00) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem[rd_addr];
                rd_busy    <= 1'b0;
            end else begin
                rd_wait <= rd_wait - 2'b01;
            end
        end
    end

    // Channel sources send tag plus a running index
    always @(posedge clk) begin
        int a_next;
        int b_next;
        a_next = a_sent + ((save_a_valid && save_a_ready) ? 1 : 0);
        b_next = b_sent + ((save_b_valid && save_b_ready) ? 1 : 0);
        a_sent <= a_next;
        b_sent <= b_next;
        if (rst) begin
            save_a_valid <= 1'b0;
            save_b_valid <= 1'b0;
        end else begin
            if (!save_a_valid || save_a_ready) begin
                save_a_valid <= !mem_stall_en || rnd[5:4] != 2'b00;
                save_a_data  <= A_TAG + word_t'(a_next);
            end
            if (!save_b_valid || save_b_ready) begin
                save_b_valid <= !mem_stall_en || rnd[7:6] != 2'b00;
                save_b_data  <= B_TAG + word_t'(b_next);
            end
        end
    end

    // Channel sinks
    always @(posedge clk) begin
        if (!rst && load_a_valid && load_a_ready) begin
            got_a.push_back(load_a_data);
        end
        if (!rst && load_b_valid && load_b_ready) begin
            got_b.push_back(load_b_data);
        end
        load_a_ready <= !rst && (!sink_stall_en || rnd[9:8] != 2'b00);
        load_b_ready <= !rst && (!sink_stall_en || rnd[11:10] != 2'b00);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic void build_expected(input int r);
        exp_img.delete();
        exp_a.delete();
        exp_b.delete();
        for (int i = 0; i < ROW_A[r] * A_ITEM_WORDS; i++) begin
            exp_a.push_back(A_TAG + word_t'(a_start + i));
        end
        for (int i = 0; i < ROW_B[r] * B_ITEM_WORDS; i++) begin
            exp_b.push_back(B_TAG + word_t'(b_start + i));
        end
        exp_img.push_back(word_t'(ROW_A[r]));
        foreach (exp_a[i]) begin
            exp_img.push_back(exp_a[i]);
        end
        exp_img.push_back(word_t'(ROW_B[r]));
        foreach (exp_b[i]) begin
            exp_img.push_back(exp_b[i]);
        end
    endfunction

    task automatic run_procedure(input bit do_save, input int accesses);
        int pulses;
        int start;
        bit seen;
        pulses = 0;
        seen   = 1'b0;
        start  = write_count + read_count;
        @(posedge clk);
        if (do_save) begin
            save <= 1'b1;
        end else begin
            load <= 1'b1;
        end
        @(posedge clk);
        save <= 1'b0;
        load <= 1'b0;
        while (!seen) begin
            @(posedge clk);
            if (complete) begin
                seen = 1'b1;
                pulses++;
                if (write_count + read_count - start != accesses || rd_busy || mem_rvalid) begin
                    errors++;
                    $display("Error at %0t: %s complete after %0d of %0d memory accesses",
                             $time, do_save ? "save" : "load",
                             write_count + read_count - start, accesses);
                end
            end
        end
        repeat (SETTLE_CYCLES) begin
            @(posedge clk);
            if (complete) begin
                pulses++;
            end
        end
        if (pulses != 1) begin
            errors++;
            $display("Error at %0t: %s complete pulsed %0d times, expected once",
                     $time, do_save ? "save" : "load", pulses);
        end
    endtask

    task automatic check_save(input int r);
        int    off;
        word_t want;
        if (a_sent - a_start != exp_a.size() || b_sent - b_start != exp_b.size()) begin
            errors++;
            $display("Error at %0t: row %0d sources gave a=%0d b=%0d words, expected %0d %0d",
                     $time, r, a_sent - a_start, b_sent - b_start, exp_a.size(), exp_b.size());
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            off = i - int'(BASE_ADDR);
            if (off >= 0 && off < exp_img.size()) begin
                want = exp_img[off];
            end else begin
                want = fill_word(addr_t'(i));
            end
            if (mem[addr_t'(i)] !== want) begin
                errors++;
                $display("Error at %0t: row %0d mem[%0h] = %h, expected %h",
                         $time, r, i, mem[addr_t'(i)], want);
            end
        end
    endtask

    task automatic check_load(input int r);
        if (got_a.size() - ga_start != exp_a.size()) begin
            errors++;
            $display("Error at %0t: row %0d sink a got %0d words, expected %0d",
                     $time, r, got_a.size() - ga_start, exp_a.size());
        end else begin
            foreach (exp_a[i]) begin
                if (got_a[ga_start + i] !== exp_a[i]) begin
                    errors++;
                    $display("Error at %0t: row %0d sink a word %0d = %h, expected %h",
                             $time, r, i, got_a[ga_start + i], exp_a[i]);
                end
            end
        end
        if (got_b.size() - gb_start != exp_b.size()) begin
            errors++;
            $display("Error at %0t: row %0d sink b got %0d words, expected %0d",
                     $time, r, got_b.size() - gb_start, exp_b.size());
        end else begin
            foreach (exp_b[i]) begin
                if (got_b[gb_start + i] !== exp_b[i]) begin
                    errors++;
                    $display("Error at %0t: row %0d sink b word %0d = %h, expected %h",
                             $time, r, i, got_b[gb_start + i], exp_b[i]);
                end
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        save    = 1'b0;
        load    = 1'b0;
        a_count = '0;
        b_count = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if ({complete, mem_valid, save_a_ready, save_b_ready, load_a_valid, load_b_valid}
                !== 6'b0) begin
            errors++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            a_count       <= count_t'(ROW_A[r]);
            b_count       <= count_t'(ROW_B[r]);
            mem_stall_en  <= ROW_MEM_STALL[r];
            sink_stall_en <= ROW_SINK_STALL[r];
            fill_req      <= 1'b1;
            @(posedge clk);
            fill_req <= 1'b0;
            @(posedge clk);
            a_start = a_sent;
            b_start = b_sent;
            build_expected(r);
            run_procedure(1'b1, exp_img.size());
            check_save(r);
            // Load has to take its lengths from the stored count words
            a_count  <= count_t'(ROW_A[r] + 9);
            b_count  <= count_t'(ROW_B[r] + 5);
            ga_start = got_a.size();
            gb_start = got_b.size();
            run_procedure(1'b0, exp_img.size());
            check_load(r);
        end
        $display("Checks done: %0d errors, %0d memory protocol errors", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/lsu_bus_pkg.sv
verilog/lsu_isa_pkg.sv
verilog/lsu_microcode_rom.sv
verilog/lsu_sequencer.sv
verilog/lsu_save_mux.sv
verilog/lsu_load_demux.sv
verilog/lsu_dma.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsu_tb -f sim.f -o lsu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
